// File: src/simd_alu_pkg.sv
package simd_alu_pkg;

	// operand word width used unless the top level overrides it
	localparam int DATA_WIDTH_DEFAULT = 64;

	// opcodes
	typedef enum logic [3:0]
	{
		ADD,
		SUB,
		SLTU,
		SLTS,
		AND,
		OR,
		XOR,
		LSL,
		LSR,
		ASR
	} alu_op_t;

	// lane sizes within one operand word
	typedef enum logic [1:0]
	{
		SZ8,
		SZ16,
		SZ32,
		SZ64
	} lane_size_t;

	// lane width in bits, 7 bits wide so that 64 fits
	function automatic logic [6:0] lane_bits(input lane_size_t size);
		case (size)
			SZ8:     return 7'd8;
			SZ16:    return 7'd16;
			SZ32:    return 7'd32;
			default: return 7'd64;
		endcase
	endfunction

endpackage

// File: src/sub_compare.sv
`timescale 1ns/10ps

module sub_compare #(parameter WIDTH = 64)
(
	input  logic [WIDTH-1:0] a,
	input  logic [WIDTH-1:0] b,
	output logic [WIDTH-1:0] diff,
	output logic             sltu,
	output logic             slts
);

	// one extra bit to hold the carry out
	logic [WIDTH:0] sum_full;
	logic           sign_a;
	logic           sign_b;
	logic           sign_r;
	logic           ovf;

	// a - b done as a + ~b + 1
	assign sum_full = {1'b0, a} + {1'b0, ~b} + {{WIDTH{1'b0}}, 1'b1};
	assign diff = sum_full[WIDTH-1:0];

	// no carry out means a borrow, so a < b unsigned
	assign sltu = ~sum_full[WIDTH];

	// sign bits of both operands and of the difference
	assign sign_a = a[WIDTH-1];
	assign sign_b = b[WIDTH-1];
	assign sign_r = sum_full[WIDTH-1];

	// overflow only when operand signs differ
	// and the result sign moved away from a
	assign ovf = (sign_a ^ sign_b) & (sign_a ^ sign_r);

	// signed less-than is N xor V, as on the 6502
	assign slts = sign_r ^ ovf;

endmodule

// File: src/barrel_shift.sv
`timescale 1ns/10ps

module barrel_shift #(parameter WIDTH = 64)
(
	input  logic [WIDTH-1:0]        value,
	input  logic [WIDTH-1:0]        amount,
	input  simd_alu_pkg::alu_op_t   kind,
	output logic [WIDTH-1:0]        shifted
);

	import simd_alu_pkg::*;

	// number of conditional stages
	localparam int STAGES = $clog2(WIDTH);

	// stage 0 is the input, the last stage is the in-range result
	logic [WIDTH-1:0] stage [0:STAGES];
	// bit shifted in from the top for right shifts
	logic             fill;
	// any amount bit at or above WIDTH
	logic             too_far;

	assign fill = (kind == ASR) & value[WIDTH-1];
	assign too_far = |amount[WIDTH-1:STAGES];

	assign stage[0] = value;

	// stage i moves by 2**i when amount bit i is set
	genvar i;
	generate
		for (i = 0; i < STAGES; i++)
		begin : g_stage
			localparam int SH = 1 << i;

			// left shift pulls zeros in at the bottom
			// right shifts pull in fill at the top
			assign stage[i+1] = !amount[i] ? stage[i]
				: (kind == LSL) ? {stage[i][WIDTH-1-SH:0], {SH{1'b0}}}
				: {{SH{fill}}, stage[i][WIDTH-1:SH]};
		end
	endgenerate

	// every bit shifted out once the amount reaches WIDTH
	always_comb
	begin
		if (too_far)
		begin
			shifted = {WIDTH{fill}};
		end
		else
		begin
			shifted = stage[STAGES];
		end
	end

endmodule

// File: src/lane_counter.sv
`timescale 1ns/10ps

module lane_counter
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  simd_alu_pkg::lane_size_t size,
	input  logic                     step,
	output logic [2:0]               lane_idx,
	output logic                     last
);

	import simd_alu_pkg::*;

	// index of the top lane, one less than the lane count
	logic [2:0] top_idx;

	always_comb
	begin
		case (size)
			SZ8:     top_idx = 3'd7;
			SZ16:    top_idx = 3'd3;
			SZ32:    top_idx = 3'd1;
			default: top_idx = 3'd0;
		endcase
	end

	// counts from the top lane down to lane 0
	// stays on lane 0 once there
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			lane_idx <= 3'd0;
		end
		else if (start)
		begin
			lane_idx <= top_idx;
		end
		else if (step && !last)
		begin
			lane_idx <= lane_idx - 3'd1;
		end
	end

	// lane 0 is always the final one written
	assign last = (lane_idx == 3'd0);

endmodule

// File: src/alu_ctrl_fsm.sv
`timescale 1ns/10ps

module alu_ctrl_fsm
(
	input  logic clk,
	input  logic rst_n,
	input  logic req,
	input  logic last,
	output logic ack,
	output logic start,
	output logic capture,
	output logic lane_en
);

	typedef enum logic [1:0]
	{
		IDLE,
		RUN,
		HOLD,
		DROP
	} state_t;

	state_t state;
	state_t state_nxt;
	logic   ack_nxt;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			state <= IDLE;
			ack <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			ack <= ack_nxt;
		end
	end

	always_comb
	begin
		state_nxt = state;
		ack_nxt = ack;
		case (state)
			// wait for a request
			IDLE:
			begin
				if (req)
				begin
					state_nxt = RUN;
				end
			end

			// one lane per cycle until lane 0 is written
			RUN:
			begin
				if (last)
				begin
					state_nxt = HOLD;
				end
			end

			// raise ack one cycle after the last lane,
			// then keep it until the requester lets go
			HOLD:
			begin
				if (!ack)
				begin
					ack_nxt = 1'b1;
				end
				else if (!req)
				begin
					ack_nxt = 1'b0;
					state_nxt = DROP;
				end
			end

			// ack already low, back to idle
			default:
			begin
				state_nxt = IDLE;
			end
		endcase
	end

	// acceptance strobes, high in the cycle before edge 0
	assign capture = (state == IDLE) && req;
	assign start = (state == IDLE) && req;

	// lane writes while running
	assign lane_en = (state == RUN);

endmodule

// File: src/lane_datapath.sv
`timescale 1ns/10ps

module lane_datapath #(parameter WIDTH_DATA = 64)
(
	input  logic                                 clk,
	input  logic                                 rst_n,
	input  logic                                 capture,
	input  simd_alu_pkg::alu_op_t                op,
	input  simd_alu_pkg::lane_size_t             size,
	input  logic [WIDTH_DATA-1:0]                a,
	input  logic [WIDTH_DATA-1:0]                b,
	input  logic                                 lane_en,
	input  logic [$clog2(WIDTH_DATA/8)-1:0]      lane_idx,
	output logic [WIDTH_DATA-1:0]                result
);

	import simd_alu_pkg::*;

	localparam logic [WIDTH_DATA-1:0] W_FULL = WIDTH_DATA'(WIDTH_DATA);
	localparam logic [WIDTH_DATA-1:0] W_ONE = WIDTH_DATA'(1);

	// request held for the whole computation
	alu_op_t                 op_q;
	lane_size_t              size_q;
	logic [WIDTH_DATA-1:0]   a_q;
	logic [WIDTH_DATA-1:0]   b_q;

	logic [WIDTH_DATA-1:0]   lane_w;
	logic [WIDTH_DATA-1:0]   lane_off;
	logic [WIDTH_DATA-1:0]   top_off;
	logic [WIDTH_DATA-1:0]   a_top;
	logic [WIDTH_DATA-1:0]   b_top;
	logic [WIDTH_DATA-1:0]   b_lane;
	logic [WIDTH_DATA-1:0]   amount;
	logic [WIDTH_DATA-1:0]   flag_one;
	logic [WIDTH_DATA-1:0]   diff;
	logic [WIDTH_DATA-1:0]   shifted;
	logic [WIDTH_DATA-1:0]   op_out;
	logic [WIDTH_DATA-1:0]   lane_mask;
	logic [WIDTH_DATA-1:0]   lane_val;
	logic                    sltu;
	logic                    slts;

	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			op_q <= op;
			size_q <= size;
			a_q <= a;
			b_q <= b;
		end
	end

	// lane geometry
	assign lane_w = WIDTH_DATA'(lane_bits(size_q));
	assign lane_off = WIDTH_DATA'(lane_idx) * lane_w;
	assign top_off = W_FULL - lane_w;

	// lane moved to the top with zeros below
	assign a_top = (a_q >> lane_off) << top_off;
	assign b_top = (b_q >> lane_off) << top_off;

	// shift amount is the b lane capped at the lane width
	assign b_lane = b_top >> top_off;
	assign amount = (b_lane >= lane_w) ? lane_w : b_lane;

	// value 1 in the lane and still top aligned
	assign flag_one = W_ONE << top_off;

	sub_compare #(.WIDTH(WIDTH_DATA)) inst_sub_compare
	(
		.a(a_top),
		.b(b_top),
		.diff(diff),
		.sltu(sltu),
		.slts(slts)
	);

	barrel_shift #(.WIDTH(WIDTH_DATA)) inst_barrel_shift
	(
		.value(a_top),
		.amount(amount),
		.kind(op_q),
		.shifted(shifted)
	);

	always_comb
	begin
		case (op_q)
			ADD:     op_out = a_top + b_top;
			SUB:     op_out = diff;
			SLTU:    op_out = sltu ? flag_one : '0;
			SLTS:    op_out = slts ? flag_one : '0;
			AND:     op_out = a_top & b_top;
			OR:      op_out = a_top | b_top;
			XOR:     op_out = a_top ^ b_top;
			LSL:     op_out = shifted;
			LSR:     op_out = shifted;
			ASR:     op_out = shifted;
			default: op_out = '0;
		endcase
	end

	// top lane bits brought back down for insertion
	assign lane_mask = {WIDTH_DATA{1'b1}} >> top_off;
	assign lane_val = op_out >> top_off;

	// cleared on acceptance and then filled one lane per cycle
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			result <= '0;
		end
		else if (capture)
		begin
			result <= '0;
		end
		else if (lane_en)
		begin
			result <= (result & ~(lane_mask << lane_off)) | (lane_val << lane_off);
		end
	end

endmodule

// File: src/simd_alu_top.sv
`timescale 1ns/10ps

module simd_alu_top #(parameter WIDTH_DATA = simd_alu_pkg::DATA_WIDTH_DEFAULT)
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     req,
	input  simd_alu_pkg::alu_op_t    op,
	input  simd_alu_pkg::lane_size_t size,
	input  logic [WIDTH_DATA-1:0]    a,
	input  logic [WIDTH_DATA-1:0]    b,
	output logic                     ack,
	output logic [WIDTH_DATA-1:0]    result
);

	localparam int IDX_W = $clog2(WIDTH_DATA / 8);

	// FSM strobes
	logic             start;
	logic             capture;
	logic             lane_en;
	// counter state
	logic [IDX_W-1:0] lane_idx;
	logic             last;

	alu_ctrl_fsm inst_fsm
	(
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.last(last),
		.ack(ack),
		.start(start),
		.capture(capture),
		.lane_en(lane_en)
	);

	// advances only on lane write cycles
	lane_counter inst_counter
	(
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.size(size),
		.step(lane_en),
		.lane_idx(lane_idx),
		.last(last)
	);

	lane_datapath #(.WIDTH_DATA(WIDTH_DATA)) inst_datapath
	(
		.clk(clk),
		.rst_n(rst_n),
		.capture(capture),
		.op(op),
		.size(size),
		.a(a),
		.b(b),
		.lane_en(lane_en),
		.lane_idx(lane_idx),
		.result(result)
	);

endmodule

// File: dv/simd_alu_sva.sv
`timescale 1ns/10ps

module simd_alu_sva #(parameter WIDTH_DATA = 64)
(
	input logic                  clk,
	input logic                  rst_n,
	input logic                  req,
	input logic                  ack,
	input logic [WIDTH_DATA-1:0] result
);

	// failure counts, one per property
	int fail_reset;
	int fail_release;
	int fail_rise;
	int fail_fall;
	int fail_stable;

	initial
	begin
		fail_reset = 0;
		fail_release = 0;
		fail_rise = 0;
		fail_fall = 0;
		fail_stable = 0;
	end

	// ack cleared by reset
	a_reset_low: assert property (@(posedge clk) !rst_n |=> !ack)
	else
	begin
		$error("ack still high after a reset cycle");
		fail_reset++;
	end

	// still low in the first cycle out of reset
	a_release_low: assert property (@(posedge clk) $rose(rst_n) |=> !ack)
	else
	begin
		$error("ack high in the cycle after reset release");
		fail_release++;
	end

	// no ack without a pending request
	a_rise_on_req: assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req)
	else
	begin
		$error("ack rose while req was low");
		fail_rise++;
	end

	// ack drops on the edge after req is seen low
	a_fall_after_req: assert property (@(posedge clk) disable iff (!rst_n) ack && !req |=> !ack)
	else
	begin
		$error("ack did not fall after req went low");
		fail_fall++;
	end

	// result frozen while acknowledged
	a_result_stable: assert property (@(posedge clk) disable iff (!rst_n) ack |=> $stable(result))
	else
	begin
		$error("result changed while ack was high");
		fail_stable++;
	end

endmodule

bind simd_alu_top simd_alu_sva #(.WIDTH_DATA(WIDTH_DATA)) i_sva
(
	.clk(clk),
	.rst_n(rst_n),
	.req(req),
	.ack(ack),
	.result(result)
);

// File: dv/tb_simd_alu.sv
`timescale 1ns/10ps

module tb_simd_alu #(parameter int SEED = 10867);

	import simd_alu_pkg::*;

	localparam int W = 64;
	// each size runs 5 arith and logic, 6 compare and 15 shift requests
	// two more for the reset scenario
	localparam int N_REQ = 4 * 26 + 2;
	// worst case request covers drive, accept, 8 lanes, ack, 10 held cycles and the drop
	localparam int REQ_CYCLES = 24;
	localparam int CYCLE_LIMIT = 10 + N_REQ * REQ_CYCLES;

	logic       clk;
	logic       rst_n;
	logic       req;
	alu_op_t    op;
	lane_size_t size;
	logic [W-1:0] a;
	logic [W-1:0] b;
	logic       ack;
	logic [W-1:0] result;
	int         errors;
	int         cycle_cnt;

	simd_alu_top #(.WIDTH_DATA(W)) i_dut
	(
		.clk(clk),
		.rst_n(rst_n),
		.req(req),
		.op(op),
		.size(size),
		.a(a),
		.b(b),
		.ack(ack),
		.result(result)
	);

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#50;
			clk = ~clk;
		end
	end

	// expected word with each lane on its own and no carry across lanes
	function automatic logic [W-1:0] expected_result(input alu_op_t o, input lane_size_t s,
		input logic [W-1:0] x, input logic [W-1:0] y);
		int w;
		int i;
		logic [W-1:0] wl;
		logic [W-1:0] mask;
		logic [W-1:0] la;
		logic [W-1:0] lb;
		logic [W-1:0] sa;
		logic [W-1:0] sb;
		logic [W-1:0] v;
		logic [W-1:0] res;
		w = 8 << s;
		wl = 64'(w);
		mask = (w == W) ? '1 : ((64'd1 << w) - 64'd1);
		res = '0;
		for (i = 0; i < W / w; i++)
		begin
			la = (x >> (i * w)) & mask;
			lb = (y >> (i * w)) & mask;
			// sign extended copies for signed compare and ASR
			sa = la[w-1] ? (la | ~mask) : la;
			sb = lb[w-1] ? (lb | ~mask) : lb;
			case (o)
				ADD:     v = la + lb;
				SUB:     v = la - lb;
				SLTU:    v = (la < lb) ? 64'd1 : 64'd0;
				SLTS:    v = ($signed(sa) < $signed(sb)) ? 64'd1 : 64'd0;
				AND:     v = la & lb;
				OR:      v = la | lb;
				XOR:     v = la ^ lb;
				LSL:     v = (lb >= wl) ? 64'd0 : (la << lb);
				LSR:     v = (lb >= wl) ? 64'd0 : (la >> lb);
				default: v = $signed(sa) >>> ((lb >= wl) ? 64'd63 : lb);
			endcase
			res = res | ((v & mask) << (i * w));
		end
		return res;
	endfunction

	// amount lanes cycling through 0, w-1, w, above w and in range
	function automatic logic [W-1:0] shift_amounts(input lane_size_t s, input int rot);
		int w;
		int i;
		logic [W-1:0] amt;
		logic [W-1:0] r;
		w = 8 << s;
		r = '0;
		for (i = 0; i < W / w; i++)
		begin
			case ((i + rot) % 5)
				0:       amt = 64'd0;
				1:       amt = 64'(w - 1);
				2:       amt = 64'(w);
				3:       amt = 64'(w + 1) + 64'($urandom_range(0, 40));
				default: amt = 64'($urandom_range(1, w - 2));
			endcase
			r = r | (amt << (i * w));
		end
		return r;
	endfunction

	// full handshake with latency and result checks and then random back-pressure
	task automatic run_request(input alu_op_t o, input lane_size_t s,
		input logic [W-1:0] x, input logic [W-1:0] y);
		logic [W-1:0] exp;
		int waited;
		int hold;
		exp = expected_result(o, s, x, y);
		op <= o;
		size <= s;
		a <= x;
		b <= y;
		req <= 1'b1;
		waited = 0;
		do
		begin
			@(posedge clk);
			waited++;
		end
		while (!ack);
		// first edge accepts and ack was set one edge before this sample
		assert (waited - 2 == (8 >> s) + 1)
		else
		begin
			$display("ERR ack latency exp=%h got=%h", (8 >> s) + 1, waited - 2);
			errors++;
		end
		assert (result == exp)
		else
		begin
			$display("ERR result exp=%h got=%h op=%s", exp, result, o.name());
			errors++;
		end
		// inputs wander while req stays high
		hold = $urandom_range(0, 10);
		repeat (hold)
		begin
			op <= alu_op_t'($urandom_range(0, 9));
			size <= lane_size_t'($urandom_range(0, 3));
			a <= {$urandom, $urandom};
			b <= {$urandom, $urandom};
			@(posedge clk);
		end
		assert (result == exp)
		else
		begin
			$display("ERR result held exp=%h got=%h", exp, result);
			errors++;
		end
		req <= 1'b0;
		do
		begin
			@(posedge clk);
		end
		while (ack);
	endtask

	initial
	begin
		int k;
		int sz;
		int rot;
		int sva_fails;
		alu_op_t cur_op;
		lane_size_t cur_sz;
		logic [W-1:0] x;
		void'($urandom(SEED));
		errors = 0;
		rst_n <= 1'b0;
		req <= 1'b0;
		op <= ADD;
		size <= SZ8;
		a <= '0;
		b <= '0;
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		for (sz = 0; sz < 4; sz++)
		begin
			cur_sz = lane_size_t'(sz);
			for (k = 0; k < 10; k++)
			begin
				cur_op = alu_op_t'(k);
				if (cur_op inside {SLTU, SLTS})
				begin
					// sign boundary both ways, zero vs all ones, equal lanes
					run_request(cur_op, cur_sz, 64'h807F_FF00_5580_01FF,
						64'h7F80_00FF_5580_02FF);
					x = {$urandom, $urandom};
					run_request(cur_op, cur_sz, x, x);
					run_request(cur_op, cur_sz, {$urandom, $urandom}, {$urandom, $urandom});
				end
				else if (cur_op inside {LSL, LSR, ASR})
				begin
					for (rot = 0; rot < 5; rot++)
					begin
						run_request(cur_op, cur_sz, {$urandom, $urandom},
							shift_amounts(cur_sz, rot));
					end
				end
				else
				begin
					run_request(cur_op, cur_sz, {$urandom, $urandom}, {$urandom, $urandom});
				end
			end
		end

		// reset lands while byte lanes are being written
		op <= ADD;
		size <= SZ8;
		a <= {$urandom, $urandom};
		b <= {$urandom, $urandom};
		req <= 1'b1;
		repeat (4) @(posedge clk);
		rst_n <= 1'b0;
		req <= 1'b0;
		// held past the edge where ack would otherwise have risen
		repeat (7) @(posedge clk);
		assert (!ack)
		else
		begin
			$display("ERR ack exp=%h got=%h", 1'b0, ack);
			errors++;
		end
		assert (result == '0)
		else
		begin
			$display("ERR result exp=%h got=%h", 64'd0, result);
			errors++;
		end
		rst_n <= 1'b1;
		@(posedge clk);
		run_request(XOR, SZ16, {$urandom, $urandom}, {$urandom, $urandom});

		sva_fails = i_dut.i_sva.fail_reset + i_dut.i_sva.fail_release
			+ i_dut.i_sva.fail_rise + i_dut.i_sva.fail_fall + i_dut.i_sva.fail_stable;
		$display("errors: %0d checks, %0d assertions", errors, sva_fails);
		if (errors == 0 && sva_fails == 0)
		begin
			$display("Test passed");
		end
		else
		begin
			$display("Test failed");
		end
		$finish;
	end

	// run limit in clock cycles
	initial
	begin
		cycle_cnt = 0;
		while (cycle_cnt < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout: run did not finish within %0d cycles, %0d errors so far",
			CYCLE_LIMIT, errors);
		$display("Test failed");
		$finish;
	end

endmodule

// File: sim.f
src/simd_alu_pkg.sv
src/sub_compare.sv
src/barrel_shift.sv
src/lane_counter.sv
src/alu_ctrl_fsm.sv
src/lane_datapath.sv
src/simd_alu_top.sv
dv/simd_alu_sva.sv
dv/tb_simd_alu.sv

// File: Makefile
# Verilator build and run of the SIMD ALU testbench

VERILATOR ?= verilator
TOP       ?= tb_simd_alu
SEED      ?= 10867
VFLAGS    ?= --binary --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell cat sim.f)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): sim.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) --Mdir $(BUILD_DIR) -f sim.f

run: $(BIN)
	$(BIN) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "Test passed" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
